// ==== Bender.yml ====
package:
  name: system_monitor

sources:
  - rtl/sysmon_pkg.sv
  - rtl/button_conditioner.sv
  - rtl/backlight_control.sv
  - rtl/battery_monitor.sv
  - rtl/panel_drivers.sv
  - rtl/system_monitor.sv
  - target: test
    files:
      - bench/system_monitor_chk.sv
      - bench/system_monitor_tb.sv

// ==== bench/system_monitor_chk.sv ====
// Concurrent assertions on the system monitor outputs, attached to the top level by bind
module system_monitor_chk (
    input logic clk,
    input logic reset,
    input logic lcd_init_done,
    input logic lcd_pwm,
    input logic low_battery,
    input logic led_green,
    input logic led_yellow
);

    // LEDs follow status one cycle after low_battery
    red_excludes_others: assert property (@(posedge clk) disable iff (reset)
        low_battery |=> !led_green && !led_yellow)
        else $error("Green or yellow LED lit while the battery is low");

    // Phase zero lights the panel even at brightness 0
    pwm_not_stuck_low: assert property (@(posedge clk) disable iff (reset)
        lcd_init_done && !lcd_pwm |->
            ##[1:sysmon_pkg::PWM_PERIOD] (lcd_pwm || !lcd_init_done))
        else $error("Backlight PWM stayed low for a whole period with the LCD ready");

    // Even full brightness drops low once per period
    pwm_not_stuck: assert property (@(posedge clk) disable iff (reset)
        lcd_pwm |-> ##[1:sysmon_pkg::PWM_PERIOD] !lcd_pwm)
        else $error("Backlight PWM stayed high for a whole period");

endmodule

bind system_monitor system_monitor_chk u_chk (
    .clk           (clk),
    .reset         (reset),
    .lcd_init_done (lcd_init_done),
    .lcd_pwm       (lcd_pwm),
    .low_battery   (low_battery),
    .led_green     (led_green),
    .led_yellow    (led_yellow)
);

// ==== bench/system_monitor_tb.sv ====
// Directed testbench for the system monitor core, compiled last and run as the simulation top
module system_monitor_tb;

    localparam int KEY_MENU       = 0;
    localparam int KEY_RIGHT      = 1;
    localparam int KEY_LEFT       = 2;
    localparam int PRESS_CYCLES   = 44;     // 20 held, 24 released
    localparam int BLOCK_CYCLES   = 260;
    localparam int WINDOW_CYCLES  = 449;    // One full PWM period
    localparam int TIMEOUT_CYCLES = 2 * (40 * PRESS_CYCLES + 10 * BLOCK_CYCLES +
                                         8 * WINDOW_CYCLES + 200);

    logic              clk = 1'b0;
    logic              reset;
    logic              btn_a, btn_b, btn_down, btn_left, btn_right;
    logic              btn_up, btn_menu, btn_sel, btn_start;
    logic              lcd_init_done, half_second_tick, second_tick;
    logic              adc_valid, charging;
    sysmon_pkg::volt_t adc_value;
    logic              menu_disabled, lcd_pwm, low_battery;
    logic              led_green, led_yellow, led_red;

    int          errors      = 0;
    int          checks      = 0;
    int          cycle_count = 0;
    logic [31:0] lfsr        = 32'hcceb_a916;
    bit          exp_menu_off = 1'b1;
    bit          exp_blink    = 1'b0;
    int          exp_bright   = sysmon_pkg::BRIGHT_RESET;

    system_monitor u_dut (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    function automatic int take_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = (value << 1) | lfsr[0];
        end
        return value;
    endfunction

    task automatic check_value(input string test, input int expected, input int actual);
        checks++;
        assert (expected == actual) else begin
            $display("Mismatch in %s: expected %0d, actual %0d", test, expected, actual);
            errors++;
        end
    endtask

    task automatic check_leds(input string test, input logic [2:0] expected);
        check_value(test, expected, {led_green, led_yellow, led_red});
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // Hold one key, release it and update the expected menu and brightness state
    task automatic press(input int key, input bit with_a);
        btn_a = with_a;
        case (key)
            KEY_MENU:  btn_menu  = 1'b0;    // Active low
            KEY_RIGHT: btn_right = 1'b1;
            default:   btn_left  = 1'b1;
        endcase
        wait_cycles(20);
        btn_a     = 1'b0;
        btn_menu  = 1'b1;
        btn_right = 1'b0;
        btn_left  = 1'b0;
        wait_cycles(24);
        if (key == KEY_MENU && !with_a) begin
            exp_menu_off = ~exp_menu_off;
        end else if (key == KEY_RIGHT && exp_menu_off && exp_bright < 15) begin
            exp_bright++;
        end else if (key == KEY_LEFT && exp_menu_off && exp_bright > 0) begin
            exp_bright--;
        end
    endtask

    task automatic measure_pwm(input string test, input int expected);
        int high;
        high = 0;
        repeat (WINDOW_CYCLES) begin
            @(negedge clk);
            if (lcd_pwm) high++;
        end
        check_value(test, expected, high);
    endtask

    task automatic tick_second();
        second_tick = 1'b1;
        @(negedge clk);
        second_tick = 1'b0;
        exp_blink   = ~exp_blink;
        wait_cycles(3);
    endtask

    // 256 samples drawn inside [lo, hi], so the block average stays in the band
    task automatic feed_block(input int lo, input int hi);
        for (int i = 0; i < 256; i++) begin
            adc_valid = 1'b1;
            adc_value = sysmon_pkg::volt_t'(lo + take_bits(10) % (hi - lo + 1));
            @(negedge clk);
        end
        adc_valid = 1'b0;
        wait_cycles(4);
    endtask

    task automatic test_reset_menu();
        check_value("reset menu_disabled", 1, menu_disabled);
        check_value("reset outputs", 0, {led_green, led_yellow, led_red, low_battery, lcd_pwm});
        press(KEY_MENU, 1'b0);
        check_value("menu toggle", exp_menu_off, menu_disabled);
        press(KEY_MENU, 1'b1);              // Combo with A
        check_value("menu combo", exp_menu_off, menu_disabled);
    endtask

    task automatic test_brightness_pwm();
        lcd_init_done    = 1'b1;
        half_second_tick = 1'b1;
        @(negedge clk);
        half_second_tick = 1'b0;
        wait_cycles(2);
        measure_pwm("pwm reset level", exp_bright * 16 + 1);
        press(KEY_RIGHT, 1'b0);             // Menu enabled, no step
        measure_pwm("pwm menu enabled", exp_bright * 16 + 1);
        press(KEY_MENU, 1'b0);
        check_value("menu disabled again", exp_menu_off, menu_disabled);
        repeat (13) press(KEY_RIGHT, 1'b0);
        measure_pwm("pwm clamp high", exp_bright * 16 + 1);
        repeat (16) press(KEY_LEFT, 1'b0);
        measure_pwm("pwm clamp low", exp_bright * 16 + 1);
        repeat (5) press(KEY_RIGHT, 1'b0);
        measure_pwm("pwm level five", exp_bright * 16 + 1);
    endtask

    task automatic test_discharge_leds();
        feed_block(1210, 1360);
        check_leds("green band", 3'b100);
        repeat (4) tick_second();
        check_leds("green before timeout", 3'b100);
        tick_second();
        check_leds("green timed out", 3'b000);
        feed_block(1080, 1190);
        check_leds("yellow band", 3'b010);
        repeat (4) tick_second();
        check_leds("yellow before timeout", 3'b010);
        tick_second();
        check_leds("yellow timed out", 3'b000);
        feed_block(1000, 1065);
        check_leds("red band", 3'b001);
        check_value("red low_battery", 1, low_battery);
        tick_second();
        check_leds("red steady", 3'b001);
        feed_block(982, 994);
        check_leds("critical blink", {2'b00, exp_blink});
        tick_second();
        check_leds("critical blink toggled", {2'b00, exp_blink});
    endtask

    task automatic test_charging();
        charging = 1'b1;
        feed_block(1210, 1360);
        check_leds("charging blink", {exp_blink, 2'b00});
        tick_second();
        check_leds("charging blink toggled", {exp_blink, 2'b00});
        feed_block(1370, 1500);
        check_leds("charged steady", 3'b100);
        tick_second();
        check_leds("charged after tick", 3'b100);
        charging = 1'b0;
    endtask

    task automatic test_low_power();
        feed_block(720, 970);
        measure_pwm("low power cut", 1);
        feed_block(1300, 1360);
        measure_pwm("low power restore", exp_bright * 16 + 1);
        feed_block(100, 690);               // Reading not trusted
        measure_pwm("invalid reading pwm", exp_bright * 16 + 1);
        check_leds("invalid reading leds", 3'b000);
    endtask

    initial begin
        reset            = 1'b1;
        btn_a            = 1'b0;
        btn_b            = 1'b0;
        btn_down         = 1'b0;
        btn_left         = 1'b0;
        btn_right        = 1'b0;
        btn_up           = 1'b0;
        btn_menu         = 1'b1;
        btn_sel          = 1'b0;
        btn_start        = 1'b0;
        lcd_init_done    = 1'b0;
        half_second_tick = 1'b0;
        second_tick      = 1'b0;
        adc_valid        = 1'b0;
        adc_value        = '0;
        charging         = 1'b0;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        test_reset_menu();
        test_brightness_pwm();
        test_discharge_leds();
        test_charging();
        test_low_power();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
rtl/sysmon_pkg.sv
rtl/button_conditioner.sv
rtl/backlight_control.sv
rtl/battery_monitor.sv
rtl/panel_drivers.sv
rtl/system_monitor.sv
bench/system_monitor_chk.sv
bench/system_monitor_tb.sv

// ==== rtl/backlight_control.sv ====
// Backlight level holder: D-pad brightness steps and the low-battery backlight cut-off
module backlight_control (
    input  logic                    clk,
    input  logic                    reset,
    input  sysmon_pkg::key_events_t key_events,
    input  logic                    menu_held,
    input  logic                    menu_disabled,
    input  sysmon_pkg::volt_t       volt,
    output sysmon_pkg::bright_t     brightness,
    output logic                    low_power
);

    sysmon_pkg::bright_t saved_level;
    logic                volt_valid;
    logic                step_enable;
    logic                enter_low;
    logic                exit_low;

    assign volt_valid  = (volt >= sysmon_pkg::VOLT_VALID_MIN);
    assign step_enable = menu_disabled & ~menu_held;

    // Hysteresis between the two thresholds
    assign enter_low = volt_valid & ~low_power & (volt < sysmon_pkg::VOLT_LOWPOWER_ENTER);
    assign exit_low  = volt_valid & low_power & (volt > sysmon_pkg::VOLT_LOWPOWER_EXIT);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            brightness <= sysmon_pkg::BRIGHT_RESET;
            low_power  <= 1'b0;
        end else begin
            if (step_enable) begin
                if (key_events.left_step && brightness != '0) begin
                    brightness <= brightness - 1'b1;
                end
                if (key_events.right_step && brightness != '1) begin
                    brightness <= brightness + 1'b1;
                end
            end

            if (low_power) begin
                brightness <= '0;               // Backlight off while battery sags
            end

            if (enter_low) begin
                low_power <= 1'b1;
            end
            if (exit_low) begin
                low_power  <= 1'b0;
                brightness <= saved_level;      // Back to level before the cut
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enter_low) begin
            saved_level <= brightness;
        end
    end

endmodule

// ==== rtl/battery_monitor.sv ====
// Battery monitor: block averaging of ADC samples, status classification and LED timeout
module battery_monitor (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     adc_valid,
    input  logic                     charging,
    input  logic                     second_tick,
    input  sysmon_pkg::volt_t        adc_value,
    output sysmon_pkg::volt_t        volt,
    output sysmon_pkg::batt_status_e status,
    output logic                     leds_timed_out,
    output logic                     low_battery
);

    sysmon_pkg::volt_sum_t            volt_sum;
    logic [sysmon_pkg::AVG_SAMPLES_LOG2:0] sample_cnt;
    logic                             block_done;
    sysmon_pkg::batt_status_e         next_status;
    logic                             green_to_yellow;
    logic [2:0]                       sec_count;

    assign block_done = sample_cnt[sysmon_pkg::AVG_SAMPLES_LOG2];   // 256 samples in

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            volt_sum   <= '0;
            sample_cnt <= '0;
            volt       <= '0;
        end else if (block_done) begin
            volt <= sysmon_pkg::volt_t'(volt_sum >> sysmon_pkg::AVG_SAMPLES_LOG2);
            if (adc_valid) begin                // First sample of next block
                volt_sum   <= sysmon_pkg::volt_sum_t'(adc_value);
                sample_cnt <= (sysmon_pkg::AVG_SAMPLES_LOG2 + 1)'(1);
            end else begin
                volt_sum   <= '0;
                sample_cnt <= '0;
            end
        end else if (adc_valid) begin
            volt_sum   <= volt_sum + sysmon_pkg::volt_sum_t'(adc_value);
            sample_cnt <= sample_cnt + 1'b1;
        end
    end

    always_comb begin
        if (volt < sysmon_pkg::VOLT_VALID_MIN) begin
            next_status = sysmon_pkg::BATT_NONE;
        end else if (charging) begin
            if (volt < sysmon_pkg::VOLT_FULL) begin
                next_status = sysmon_pkg::BATT_CHARGING;
            end else begin
                next_status = sysmon_pkg::BATT_FULL;
            end
        end else if (volt < sysmon_pkg::VOLT_CRIT) begin
            next_status = sysmon_pkg::BATT_CRITICAL;
        end else if (volt < sysmon_pkg::VOLT_RED) begin
            next_status = sysmon_pkg::BATT_RED;
        end else if (volt < sysmon_pkg::VOLT_YELLOW) begin
            next_status = sysmon_pkg::BATT_YELLOW;
        end else begin
            next_status = sysmon_pkg::BATT_GREEN;
        end
    end

    assign green_to_yellow = (status == sysmon_pkg::BATT_GREEN) &&
                             (next_status == sysmon_pkg::BATT_YELLOW);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            status    <= sysmon_pkg::BATT_NONE;
            sec_count <= '0;
        end else begin
            status <= next_status;
            if (charging || green_to_yellow) begin
                sec_count <= '0;
            end else if (second_tick && sec_count != 3'd7) begin
                sec_count <= sec_count + 1'b1;
            end
        end
    end

    assign leds_timed_out = (sec_count >= sysmon_pkg::LED_ON_SECONDS);
    assign low_battery    = (status == sysmon_pkg::BATT_CRITICAL) ||
                            (status == sysmon_pkg::BATT_RED);

endmodule

// ==== rtl/button_conditioner.sv ====
// Button input stage: two-flop synchronizers, debounce histories and the menu mode toggle
module button_conditioner (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    btn_a,
    input  logic                    btn_b,
    input  logic                    btn_down,
    input  logic                    btn_left,
    input  logic                    btn_right,
    input  logic                    btn_up,
    input  logic                    btn_menu,       // Pressed when 0
    input  logic                    btn_sel,
    input  logic                    btn_start,
    output sysmon_pkg::buttons_t    buttons,
    output sysmon_pkg::key_events_t key_events,
    output logic                    menu_disabled
);

    sysmon_pkg::buttons_t  sync_1;
    sysmon_pkg::debounce_t left_hist;
    sysmon_pkg::debounce_t right_hist;
    sysmon_pkg::debounce_t menu_hist;
    logic                  menu_armed;
    logic                  other_pressed;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync_1  <= '0;
            buttons <= '0;
        end else begin
            sync_1 <= '{a: btn_a, b: btn_b, down: btn_down, left: btn_left,
                        right: btn_right, up: btn_up, menu: ~btn_menu,
                        sel: btn_sel, start: btn_start};
            buttons <= sync_1;
        end
    end

    // Menu history is kept in pin polarity, idle high
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            left_hist  <= '0;
            right_hist <= '0;
            menu_hist  <= '1;
        end else begin
            left_hist  <= {left_hist[14:0], buttons.left};
            right_hist <= {right_hist[14:0], buttons.right};
            menu_hist  <= {menu_hist[14:0], ~buttons.menu};
        end
    end

    assign key_events.left_step  = (left_hist == sysmon_pkg::PRESS_PATTERN);
    assign key_events.right_step = (right_hist == sysmon_pkg::PRESS_PATTERN);

    assign other_pressed = buttons.a | buttons.b | buttons.down | buttons.up |
                           buttons.left | buttons.right | buttons.sel | buttons.start;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            menu_armed    <= 1'b0;
            menu_disabled <= 1'b1;
        end else begin
            if (menu_armed && menu_hist == sysmon_pkg::RELEASE_PATTERN) begin
                menu_disabled <= ~menu_disabled;
            end
            if (other_pressed) begin
                menu_armed <= 1'b0;             // Combo, not a menu press
            end else if (menu_hist == sysmon_pkg::PRESS_PATTERN) begin
                menu_armed <= 1'b1;
            end else if (menu_hist == sysmon_pkg::RELEASE_PATTERN) begin
                menu_armed <= 1'b0;
            end
        end
    end

endmodule

// ==== rtl/panel_drivers.sv ====
// Panel outputs: LCD backlight PWM and the three battery status LEDs with blinking
module panel_drivers (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     lcd_init_done,
    input  logic                     half_second_tick,
    input  logic                     second_tick,
    input  sysmon_pkg::bright_t      brightness,
    input  sysmon_pkg::batt_status_e status,
    input  logic                     leds_timed_out,
    output logic                     lcd_pwm,
    output logic                     led_green,
    output logic                     led_yellow,
    output logic                     led_red
);

    sysmon_pkg::pwm_count_t phase;
    logic                   bl_enable;
    logic                   blink;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase     <= '0;
            bl_enable <= 1'b0;
            blink     <= 1'b0;
        end else begin
            if (phase == sysmon_pkg::pwm_count_t'(sysmon_pkg::PWM_PERIOD - 1)) begin
                phase <= '0;
            end else begin
                phase <= phase + 1'b1;
            end
            if (half_second_tick) begin
                bl_enable <= 1'b1;              // Panel settled after first half second
            end
            if (second_tick) begin
                blink <= ~blink;
            end
        end
    end

    // High for brightness*16+1 phases per period
    assign lcd_pwm = lcd_init_done & bl_enable &
                     (phase <= sysmon_pkg::pwm_count_t'({brightness, 4'b0000}));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            led_green  <= 1'b0;
            led_yellow <= 1'b0;
            led_red    <= 1'b0;
        end else begin
            led_green  <= 1'b0;
            led_yellow <= 1'b0;
            led_red    <= 1'b0;
            case (status)
                sysmon_pkg::BATT_CHARGING: led_green  <= blink;
                sysmon_pkg::BATT_FULL:     led_green  <= 1'b1;
                sysmon_pkg::BATT_CRITICAL: led_red    <= blink;
                sysmon_pkg::BATT_RED:      led_red    <= 1'b1;
                sysmon_pkg::BATT_YELLOW:   led_yellow <= ~leds_timed_out;
                sysmon_pkg::BATT_GREEN:    led_green  <= ~leds_timed_out;
                default: ;                      // No valid reading
            endcase
        end
    end

endmodule

// ==== rtl/sysmon_pkg.sv ====
// Shared types, thresholds and debounce patterns of the system monitor, compiled before all RTL
package sysmon_pkg;

    typedef logic [13:0] volt_t;        // ADC units
    typedef logic [21:0] volt_sum_t;    // Sum of 256 readings
    typedef logic [3:0]  bright_t;      // Backlight level 0..15
    typedef logic [8:0]  pwm_count_t;   // PWM phase
    typedef logic [15:0] debounce_t;    // Oldest sample in bit 15

    // Synchronized button levels, menu already inverted to pressed-high
    typedef struct packed {
        logic a;
        logic b;
        logic down;
        logic left;
        logic right;
        logic up;
        logic menu;
        logic sel;
        logic start;
    } buttons_t;

    typedef struct packed {
        logic left_step;
        logic right_step;
    } key_events_t;

    typedef enum logic [2:0] {
        BATT_NONE,
        BATT_CHARGING,
        BATT_FULL,
        BATT_CRITICAL,
        BATT_RED,
        BATT_YELLOW,
        BATT_GREEN
    } batt_status_e;

    localparam debounce_t PRESS_PATTERN   = 16'h8000;
    localparam debounce_t RELEASE_PATTERN = 16'h7FFF;

    localparam int PWM_PERIOD       = 449;     // Phase runs 0..448
    localparam int AVG_SAMPLES_LOG2 = 8;

    // AA cell thresholds
    localparam volt_t VOLT_VALID_MIN      = 14'd700;    // ~1.8 V
    localparam volt_t VOLT_LOWPOWER_ENTER = 14'd979;    // ~2.55 V
    localparam volt_t VOLT_LOWPOWER_EXIT  = 14'd1293;   // ~3.4 V
    localparam volt_t VOLT_FULL           = 14'd1367;   // ~3.6 V
    localparam volt_t VOLT_CRIT           = 14'd997;    // ~2.6 V
    localparam volt_t VOLT_RED            = 14'd1071;   // ~2.8 V
    localparam volt_t VOLT_YELLOW         = 14'd1200;   // ~3.15 V

    localparam logic [2:0] LED_ON_SECONDS = 3'd5;
    localparam bright_t    BRIGHT_RESET   = 4'd3;

endpackage

// ==== rtl/system_monitor.sv ====
// System monitor top level: wires the button stage, backlight and battery logic and panel outputs
module system_monitor (
    input  logic              clk,
    input  logic              reset,
    input  logic              btn_a,
    input  logic              btn_b,
    input  logic              btn_down,
    input  logic              btn_left,
    input  logic              btn_right,
    input  logic              btn_up,
    input  logic              btn_menu,         // Pressed when 0
    input  logic              btn_sel,
    input  logic              btn_start,
    input  logic              lcd_init_done,
    input  logic              half_second_tick,
    input  logic              second_tick,
    input  logic              adc_valid,
    input  sysmon_pkg::volt_t adc_value,
    input  logic              charging,         // PMIC charge bit
    output logic              menu_disabled,
    output logic              lcd_pwm,
    output logic              low_battery,
    output logic              led_green,
    output logic              led_yellow,
    output logic              led_red
);

    sysmon_pkg::buttons_t     buttons;
    sysmon_pkg::key_events_t  key_events;
    sysmon_pkg::volt_t        volt;
    sysmon_pkg::bright_t      brightness;
    sysmon_pkg::batt_status_e status;
    logic                     leds_timed_out;

    button_conditioner u_buttons (
        .clk           (clk),
        .reset         (reset),
        .btn_a         (btn_a),
        .btn_b         (btn_b),
        .btn_down      (btn_down),
        .btn_left      (btn_left),
        .btn_right     (btn_right),
        .btn_up        (btn_up),
        .btn_menu      (btn_menu),
        .btn_sel       (btn_sel),
        .btn_start     (btn_start),
        .buttons       (buttons),
        .key_events    (key_events),
        .menu_disabled (menu_disabled)
    );

    backlight_control u_backlight (
        .clk           (clk),
        .reset         (reset),
        .key_events    (key_events),
        .menu_held     (buttons.menu),
        .menu_disabled (menu_disabled),
        .volt          (volt),
        .brightness    (brightness),
        .low_power     ()
    );

    battery_monitor u_battery (
        .clk            (clk),
        .reset          (reset),
        .adc_valid      (adc_valid),
        .charging       (charging),
        .second_tick    (second_tick),
        .adc_value      (adc_value),
        .volt           (volt),
        .status         (status),
        .leds_timed_out (leds_timed_out),
        .low_battery    (low_battery)
    );

    panel_drivers u_panel (
        .clk              (clk),
        .reset            (reset),
        .lcd_init_done    (lcd_init_done),
        .half_second_tick (half_second_tick),
        .second_tick      (second_tick),
        .brightness       (brightness),
        .status           (status),
        .leds_timed_out   (leds_timed_out),
        .lcd_pwm          (lcd_pwm),
        .led_green        (led_green),
        .led_yellow       (led_yellow),
        .led_red          (led_red)
    );

endmodule
